// File: bench/wb_unit_tb.sv
// Results are expected exactly three negedges after issue; test addresses stay below 1 KiB.
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_unit_tb import mips_op_pkg::*, mem_bus_pkg::*; ();

    localparam int IDX_W       = $clog2(`WB_RAM_WORDS);
    localparam int N_OPS       = 80;
    localparam int WATCHDOG_NS = N_OPS * 4 * 2 + 400;

    typedef struct {
        int       tag;
        logic     we;
        logic     stall;
        word_t    data;
        reg_idx_t dest;
    } expect_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    alu_op_t  in_op;
    word_t    in_alures;
    word_t    in_mulres;
    addr_t    in_vaddr;
    word_t    in_store_data;
    reg_idx_t in_dest;
    logic     wb_we;
    reg_idx_t wb_dest;
    word_t    wb_data;
    logic     stallreq;

    word_t   shadow [`WB_RAM_WORDS];
    expect_t exp_q [$];
    expect_t due;
    integer  seed;
    int      cyc = 0;
    int      n_checks = 0;
    int      n_errors = 0;

    wb_unit dut0 (.*);

    always #2 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [IDX_W-1:0] word_index(input addr_t va);
        return va[IDX_W+1:2];
    endfunction

    function automatic logic writes_reg(input alu_op_t op);
        case (op)
            ALU_NOP, ALU_WAIT, ALU_SB, ALU_SH, ALU_SW: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    // Register write data from the stored word and the byte offset.
    function automatic word_t expected_data(input alu_op_t op, input word_t alu,
                                            input word_t mul, input addr_t va, input word_t w);
        int          sh;
        logic [7:0]  b;
        logic [15:0] h;
        sh = 8 * int'(va[1:0]);
        b  = 8'(w >> sh);
        h  = 16'(w >> sh);
        case (op)
            ALU_LB:         return {{24{b[7]}}, b};
            ALU_LBU:        return {24'h0, b};
            ALU_LH:         return va[0] ? '0 : {{16{h[15]}}, h};
            ALU_LHU:        return va[0] ? '0 : {16'h0, h};
            ALU_LW, ALU_LL: return w;
            ALU_LWL:        return w << (24 - sh);
            ALU_LWR:        return w >> sh;
            ALU_MUL:        return mul;
            default:        return alu;
        endcase
    endfunction

    task automatic model_store(input alu_op_t op, input addr_t va, input word_t sd);
        int sh;
        sh = 8 * int'(va[1:0]);
        case (op)
            ALU_SB: shadow[word_index(va)][sh +: 8] = sd[7:0];
            ALU_SH: if (!va[0]) shadow[word_index(va)][sh +: 16] = sd[15:0];
            ALU_SW: if (va[1:0] == 2'b00) shadow[word_index(va)] = sd;
            default: ;
        endcase
    endtask

    // One operation per call, on the next rising edge.
    task automatic issue(input alu_op_t op, input addr_t va);
        expect_t  e;
        word_t    alu;
        word_t    mul;
        word_t    sd;
        reg_idx_t d;
        alu = $random(seed);
        mul = $random(seed);
        sd  = $random(seed);
        d   = reg_idx_t'($random(seed));
        @(posedge clk);
        in_valid      <= 1'b1;
        in_op         <= op;
        in_alures     <= alu;
        in_mulres     <= mul;
        in_vaddr      <= va;
        in_store_data <= sd;
        in_dest       <= d;
        e.tag   = cyc;
        e.we    = writes_reg(op);
        e.stall = (op == ALU_WAIT);
        e.data  = expected_data(op, alu, mul, va, shadow[word_index(va)]);
        e.dest  = d;
        exp_q.push_back(e);
        model_store(op, va, sd);
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    // Every cycle out of reset is checked, bubbles included.
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rst_n) begin
            if (exp_q.size() != 0 && exp_q[0].tag + 3 == cyc) begin
                due = exp_q.pop_front();
                check_bit("wb_we", wb_we, due.we);
                check_bit("stallreq", stallreq, due.stall);
                if (due.we) begin
                    check_word("wb_data", wb_data, due.data);
                    check_reg("wb_dest", wb_dest, due.dest);
                end
            end else begin
                check_bit("wb_we", wb_we, 1'b0);
                check_bit("stallreq", stallreq, 1'b0);
            end
        end
    end

    task automatic test_reg_ops();
        @(negedge clk);
        check_bit("wb_we", wb_we, 1'b0);
        check_bit("stallreq", stallreq, 1'b0);
        issue(ALU_ADD, 32'h0);
        issue(ALU_MUL, 32'h0);
        drain();
    endtask

    task automatic test_word_access();
        addr_t addrs [4];
        for (int i = 0; i < 4; i++) begin
            addrs[i] = addr_t'($random(seed)) & 32'h0000_03fc;
            issue(ALU_SW, addrs[i]);
        end
        for (int i = 0; i < 4; i++) issue(ALU_LW, addrs[i]);
        for (int i = 0; i < 4; i++) issue(ALU_LL, addrs[i]);
        issue(ALU_SW, addrs[0] + 2);
        issue(ALU_SW, addrs[0] + 1);
        issue(ALU_LW, addrs[0]);
        drain();
    endtask

    task automatic test_byte_half();
        for (int ofs = 0; ofs < 4; ofs++) begin
            issue(ALU_SW, 32'h100);
            issue(ALU_SB, 32'h100 + ofs);
            issue(ALU_LB, 32'h100 + ofs);
            issue(ALU_LBU, 32'h100 + ofs);
            issue(ALU_LW, 32'h100);
        end
        for (int ofs = 0; ofs < 4; ofs++) begin
            issue(ALU_SW, 32'h104);
            issue(ALU_SH, 32'h104 + ofs);
            issue(ALU_LH, 32'h104 + ofs);
            issue(ALU_LHU, 32'h104 + ofs);
            issue(ALU_LW, 32'h104);
        end
        drain();
    endtask

    task automatic test_partial();
        issue(ALU_SW, 32'h200);
        for (int ofs = 0; ofs < 4; ofs++) begin
            issue(ALU_LWL, 32'h200 + ofs);
            issue(ALU_LWR, 32'h200 + ofs);
        end
        drain();
    endtask

    task automatic test_wait_mix();
        issue(ALU_WAIT, 32'h0);
        drain();
        issue(ALU_SW, 32'h300);
        issue(ALU_LW, 32'h300);
        issue(ALU_SB, 32'h301);
        issue(ALU_LBU, 32'h301);
        issue(ALU_SH, 32'h302);
        issue(ALU_LH, 32'h302);
        issue(ALU_ADD, 32'h0);
        issue(ALU_LW, 32'h300);
        drain();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed          = 32'hdfb0_621b;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_op         = ALU_NOP;
        in_alures     = '0;
        in_mulres     = '0;
        in_vaddr      = '0;
        in_store_data = '0;
        in_dest       = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reg_ops();
        test_word_access();
        test_byte_half();
        test_partial();
        test_wait_mix();
        $display("checks=%0d errors=%0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
// Single port, no read-during-write bypass; addresses beyond the depth wrap on the low bits.
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module data_ram import mem_bus_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    mem_if.memory bus
);

    localparam int IDX_W = $clog2(`WB_RAM_WORDS);
    localparam int LANES = `WB_DATA_W / 8;

    word_t            mem [`WB_RAM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = bus.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (bus.be[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read word held until the next read.
    always_ff @(posedge clk) begin
        if (bus.re) begin
            bus.rdata <= mem[idx];
        end
    end

    // Catches an address from the access unit that would alias.
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        bus.we |-> (bus.addr < `WB_RAM_WORDS));

endmodule

`default_nettype wire

// File: hw/load_align.sv
// Misaligned LH/LHU return zero; LWL/LWR zero-fill and do not merge with the old register.
`timescale 1ns/1ps
`default_nettype none

module load_align import mips_op_pkg::*, mem_bus_pkg::*; (
    input  logic    valid,
    input  alu_op_t op,
    input  word_t   alures,
    input  word_t   mulres,
    input  addr_t   vaddr,
    input  word_t   rdata,
    output word_t   wrdata,
    output logic    we,
    output logic    stallreq
);

    logic [1:0] ofs;

    assign ofs = vaddr[1:0];

    assign we       = valid && (is_load(op) || op == ALU_ADD || op == ALU_MUL);
    assign stallreq = valid && (op == ALU_WAIT);

    always_comb begin
        case (op)
            ALU_LB: begin
                case (ofs)
                    2'b00: wrdata = {{24{rdata[7]}}, rdata[7:0]};
                    2'b01: wrdata = {{24{rdata[15]}}, rdata[15:8]};
                    2'b10: wrdata = {{24{rdata[23]}}, rdata[23:16]};
                    2'b11: wrdata = {{24{rdata[31]}}, rdata[31:24]};
                endcase
            end
            ALU_LBU: begin
                case (ofs)
                    2'b00: wrdata = {24'b0, rdata[7:0]};
                    2'b01: wrdata = {24'b0, rdata[15:8]};
                    2'b10: wrdata = {24'b0, rdata[23:16]};
                    2'b11: wrdata = {24'b0, rdata[31:24]};
                endcase
            end
            ALU_LH: begin
                case (ofs)
                    2'b00:   wrdata = {{16{rdata[15]}}, rdata[15:0]};
                    2'b10:   wrdata = {{16{rdata[31]}}, rdata[31:16]};
                    default: wrdata = '0;
                endcase
            end
            ALU_LHU: begin
                case (ofs)
                    2'b00:   wrdata = {16'b0, rdata[15:0]};
                    2'b10:   wrdata = {16'b0, rdata[31:16]};
                    default: wrdata = '0;
                endcase
            end
            ALU_LW, ALU_LL: begin
                wrdata = rdata;
            end
            // Left part: read word moves up.
            ALU_LWL: begin
                case (ofs)
                    2'b00: wrdata = {rdata[7:0], 24'b0};
                    2'b01: wrdata = {rdata[15:0], 16'b0};
                    2'b10: wrdata = {rdata[23:0], 8'b0};
                    2'b11: wrdata = rdata;
                endcase
            end
            // Right part: read word moves down.
            ALU_LWR: begin
                case (ofs)
                    2'b00: wrdata = rdata;
                    2'b01: wrdata = {8'b0, rdata[31:8]};
                    2'b10: wrdata = {16'b0, rdata[31:16]};
                    2'b11: wrdata = {24'b0, rdata[31:24]};
                endcase
            end
            ALU_MUL: wrdata = mulres;
            default: wrdata = alures;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mem_access.sv
// Misaligned SH/SW are dropped with no enables and no trap; loads read the whole word.
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module mem_access import mips_op_pkg::*, mem_bus_pkg::*; (
    input  logic       valid,
    input  mem_stage_t stage,
    mem_if.requester   bus
);

    logic [1:0] ofs;
    logic       aligned;
    byte_en_t   lanes;

    assign ofs = stage.vaddr[1:0];

    always_comb begin
        lanes     = '0;
        aligned   = 1'b1;
        bus.wdata = stage.sdata;
        case (stage.op)
            ALU_SB: begin
                lanes     = byte_en_t'(4'b0001 << ofs);
                bus.wdata = {4{stage.sdata[7:0]}};
            end
            ALU_SH: begin
                aligned   = !ofs[0];
                lanes     = ofs[1] ? 4'b1100 : 4'b0011;
                bus.wdata = {2{stage.sdata[15:0]}};
            end
            ALU_SW: begin
                aligned = (ofs == 2'b00);
                lanes   = 4'b1111;
            end
            default: begin
                lanes = '0;
            end
        endcase
    end

    // Word index for the RAM.
    assign bus.addr = {2'b00, stage.vaddr[`WB_ADDR_W-1:2]};
    assign bus.be   = aligned ? lanes : '0;
    assign bus.we   = valid && is_store(stage.op) && aligned;
    assign bus.re   = valid && is_load(stage.op);

endmodule

`default_nettype wire

// File: hw/mem_bus_pkg.sv
// Byte lanes are little-endian within a word; the payload structs assume the opcode package.
`default_nettype none

`include "wb_params.svh"

package mem_bus_pkg;

    import mips_op_pkg::*;

    typedef logic [`WB_DATA_W-1:0]   word_t;
    typedef logic [`WB_ADDR_W-1:0]   addr_t;
    typedef logic [`WB_DATA_W/8-1:0] byte_en_t;
    typedef logic [`WB_REG_W-1:0]    reg_idx_t;

    // Operation as it enters the memory stage.
    typedef struct packed {
        alu_op_t  op;
        word_t    alures;
        word_t    mulres;
        addr_t    vaddr;
        word_t    sdata;
        reg_idx_t dest;
    } mem_stage_t;

    // Store data is dropped here.
    typedef struct packed {
        alu_op_t  op;
        word_t    alures;
        word_t    mulres;
        addr_t    vaddr;
        reg_idx_t dest;
    } wb_stage_t;

endpackage

`default_nettype wire

// File: hw/mem_if.sv
// No handshake: a request is taken at the closing edge and rdata is valid the cycle after.
`timescale 1ns/1ps
`default_nettype none

interface mem_if import mem_bus_pkg::*; ();

    // Word address, not byte address.
    addr_t    addr;
    byte_en_t be;
    logic     we;
    word_t    wdata;
    logic     re;
    word_t    rdata;

    modport requester (
        output addr, be, we, wdata, re,
        input  rdata
    );

    modport memory (
        input  addr, be, we, wdata, re,
        output rdata
    );

endinterface

`default_nettype wire

// File: hw/mips_op_pkg.sv
// Opcode set covers only the memory and writeback slice; LL is treated as a plain LW.
`default_nettype none

package mips_op_pkg;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_MUL,
        ALU_WAIT,
        ALU_LB,
        ALU_LBU,
        ALU_LH,
        ALU_LHU,
        ALU_LW,
        ALU_LL,
        ALU_LWL,
        ALU_LWR,
        ALU_SB,
        ALU_SH,
        ALU_SW
    } alu_op_t;

    function automatic logic is_load(input alu_op_t op);
        return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LL, ALU_LWL, ALU_LWR};
    endfunction

    function automatic logic is_store(input alu_op_t op);
        return op inside {ALU_SB, ALU_SH, ALU_SW};
    endfunction

endpackage

`default_nettype wire

// File: hw/pipe_stage.sv
// Payload is not reset, only the valid bit; consumers must qualify data with out_valid.
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

    // Valid must stay known once out of reset, or the stages downstream misfire.
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

`default_nettype wire

// File: hw/wb_unit.sv
// Fixed two-cycle latency with no back-pressure; stallreq is reported only.
`timescale 1ns/1ps
`default_nettype none

module wb_unit import mips_op_pkg::*, mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  alu_op_t  in_op,
    input  word_t    in_alures,
    input  word_t    in_mulres,
    input  addr_t    in_vaddr,
    input  word_t    in_store_data,
    input  reg_idx_t in_dest,
    output logic     wb_we,
    output reg_idx_t wb_dest,
    output word_t    wb_data,
    output logic     stallreq
);

    mem_stage_t mem_d;
    mem_stage_t mem_q;
    logic       mem_valid;
    wb_stage_t  wb_d;
    wb_stage_t  wb_q;
    logic       wb_valid;

    mem_if ram_bus ();

    assign mem_d = '{op: in_op, alures: in_alures, mulres: in_mulres, vaddr: in_vaddr,
                     sdata: in_store_data, dest: in_dest};

    pipe_stage #(.payload_t(mem_stage_t)) stage_mem (
        .clk, .rst_n,
        .in_valid (in_valid),  .in_data  (mem_d),
        .out_valid(mem_valid), .out_data (mem_q)
    );

    mem_access access0 (.valid(mem_valid), .stage(mem_q), .bus(ram_bus.requester));

    data_ram ram0 (.clk, .rst_n, .bus(ram_bus.memory));

    assign wb_d = '{op: mem_q.op, alures: mem_q.alures, mulres: mem_q.mulres,
                    vaddr: mem_q.vaddr, dest: mem_q.dest};

    pipe_stage #(.payload_t(wb_stage_t)) stage_wb (
        .clk, .rst_n,
        .in_valid (mem_valid), .in_data  (wb_d),
        .out_valid(wb_valid),  .out_data (wb_q)
    );

    load_align align0 (
        .valid   (wb_valid),
        .op      (wb_q.op),
        .alures  (wb_q.alures),
        .mulres  (wb_q.mulres),
        .vaddr   (wb_q.vaddr),
        .rdata   (ram_bus.rdata),
        .wrdata  (wb_data),
        .we      (wb_we),
        .stallreq(stallreq)
    );

    assign wb_dest = wb_q.dest;

endmodule

`default_nettype wire

// File: include/wb_params.svh
// Widths assume 32-bit words with four byte lanes; the RAM depth must be a power of two.
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// Data word width in bits.
`define WB_DATA_W 32

// Byte address width.
`define WB_ADDR_W 32

// Data RAM depth in words.
`define WB_RAM_WORDS 256

// Register-file index width.
`define WB_REG_W 5

`endif

// File: run.sh
#!/usr/bin/env bash
# Builds the wb_unit testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module wb_unit_tb \
    -Mdir obj_dir -o wb_sim \
    || { echo "Verilator build failed."; exit 1; }

./obj_dir/wb_sim | tee /dev/stderr | grep -qxF '*** TEST PASSED ***' \
    && exit 0 \
    || exit 1

// File: sim.f
+incdir+include
hw/mips_op_pkg.sv
hw/mem_bus_pkg.sv
hw/mem_if.sv
hw/pipe_stage.sv
hw/mem_access.sv
hw/data_ram.sv
hw/load_align.sv
hw/wb_unit.sv
bench/wb_unit_tb.sv
